//--- hdl/gb_bus_pkg.sv
package gb_bus_pkg;

	// ******************************************************************
	// bus widths.
	// ******************************************************************
	localparam int ADR_W      = 16;
	localparam int DATA_W     = 8;
	localparam int VRAM_ADR_W = 13;
	localparam int OAM_ADR_W  = 8;

	// ******************************************************************
	// console memory map.
	// ******************************************************************
	localparam logic [ADR_W-1:0] BOOT_TOP  = 16'h0100;
	localparam logic [ADR_W-1:0] ROM_TOP   = 16'h8000;
	localparam logic [ADR_W-1:0] VRAM_BASE = 16'h8000;
	localparam logic [ADR_W-1:0] XRAM_BASE = 16'ha000;
	localparam logic [ADR_W-1:0] WRAM_BASE = 16'hc000;
	localparam logic [ADR_W-1:0] OAM_BASE  = 16'hfe00;
	localparam logic [ADR_W-1:0] OAM_TOP   = 16'hfea0;
	localparam logic [ADR_W-1:0] IO_PAGE   = 16'hff00;

	// register offsets inside the i/o page.
	localparam logic [7:0] IO_JOYP    = 8'h00;
	localparam logic [7:0] IO_SER_LO  = 8'h01;
	localparam logic [7:0] IO_SER_HI  = 8'h02;
	localparam logic [7:0] IO_TIM_LO  = 8'h04;
	localparam logic [7:0] IO_TIM_HI  = 8'h07;
	localparam logic [7:0] IO_IF      = 8'h0f;
	localparam logic [7:0] IO_SND_LO  = 8'h10;
	localparam logic [7:0] IO_SND_HI  = 8'h3f;
	localparam logic [7:0] IO_PPU_LO  = 8'h40;
	localparam logic [7:0] IO_PPU_HI  = 8'h4b;
	localparam logic [7:0] IO_BROM    = 8'h50;
	localparam logic [7:0] IO_HRAM_LO = 8'h80;
	localparam logic [7:0] IO_HRAM_HI = 8'hfe;
	localparam logic [7:0] IO_IE      = 8'hff;

	localparam int               RST_TICK_W = 4;
	localparam logic [DATA_W-1:0] BUS_IDLE  = 8'hff;

	// ******************************************************************
	// bus types.
	// ******************************************************************
	typedef struct packed {
		logic [7:0] page;
		logic [7:0] ofs;
	} io_adr_t;

	// a bus address, seen whole by the memory map or split by the i/o decoder.
	typedef union packed {
		logic [ADR_W-1:0] raw;
		io_adr_t          pg;
	} gb_adr_u;

	typedef struct packed {
		logic brom;
		logic rom;
		logic vram;
		logic xram;
		logic wram;
		logic oam;
		logic io;
	} mem_sel_t;

	typedef struct packed {
		logic joypad;
		logic serial;
		logic timer;
		logic int_flag;
		logic sound;
		logic ppu;
		logic brom;
		logic hram;
		logic int_ena;
	} io_sel_t;

	typedef struct packed {
		logic [ADR_W-1:0]  adr;
		logic              rd;
		logic              wr;
		logic [DATA_W-1:0] wdata;
	} cpu_bus_t;

	typedef struct packed {
		logic [ADR_W-1:0]     adr_rd;
		logic [OAM_ADR_W-1:0] adr_oam;
		logic                 rd;
		logic                 wr;
		logic                 active;
		logic [DATA_W-1:0]    wdata;
	} dma_bus_t;

	typedef struct packed {
		logic [ADR_W-1:0] adr;
		logic             rd;
		logic             need_vram;
		logic             need_oam;
	} ppu_bus_t;

	typedef struct packed {
		logic [DATA_W-1:0] hram;
		logic [DATA_W-1:0] joy;
		logic [DATA_W-1:0] sio;
		logic [DATA_W-1:0] tim;
		logic [DATA_W-1:0] snd;
		logic [DATA_W-1:0] ppu;
		logic [DATA_W-1:0] cpureg;
		logic [DATA_W-1:0] brom;
		logic [DATA_W-1:0] vram;
		logic [DATA_W-1:0] oam;
		logic [DATA_W-1:0] ext;
	} dev_rdata_t;

	typedef struct packed {
		logic [ADR_W-1:0]  adr;
		logic              rd;
		logic              wr;
		logic [DATA_W-1:0] wdata;
	} mem_port_t;

	typedef struct packed {
		logic [ADR_W-1:0] adr;
		logic             rd;
		logic             wr;
		logic             data_oe;
		logic             cs_rom;
		logic             cs_xram;
		logic             cs_wram;
	} ext_port_t;

	typedef enum logic [1:0] {
		RST_ASSERT,
		RST_RELEASE,
		RST_DONE
	} rst_state_e;

endpackage

//--- hdl/gb_memmap.sv
`timescale 1ns/100ps

module gb_memmap import gb_bus_pkg::*; (
	input  gb_adr_u  adr,
	input  logic     enable,
	input  logic     boot_en,
	output mem_sel_t sel
);

	always_comb begin
		sel = '0;
		if (enable) begin
			if (adr.raw >= IO_PAGE) begin
				sel.io = 1'b1;
			end else if (adr.raw >= OAM_BASE) begin
				// fea0..feff is left unmapped.
				sel.oam = (adr.raw < OAM_TOP);
			end else if (adr.raw >= WRAM_BASE) begin
				// includes the echo area above wram.
				sel.wram = 1'b1;
			end else if (adr.raw >= XRAM_BASE) begin
				sel.xram = 1'b1;
			end else if (adr.raw >= VRAM_BASE) begin
				sel.vram = 1'b1;
			end else if (adr.raw < ROM_TOP) begin
				if (boot_en && adr.raw < BOOT_TOP) begin
					sel.brom = 1'b1;
				end else begin
					sel.rom = 1'b1;
				end
			end
		end
	end

	// every value that the selects hold must name at most one region.
	a_one_region: assert property (@(sel) $onehot0(sel))
		else $error("gb_memmap: more than one region selected");

endmodule

//--- hdl/gb_iomap.sv
`timescale 1ns/100ps

module gb_iomap import gb_bus_pkg::*; (
	input  gb_adr_u adr,
	input  logic    io,
	output io_sel_t sel
);

	logic       page_hit;
	logic [7:0] ofs;

	assign page_hit = io && (adr.pg.page == IO_PAGE[ADR_W-1:8]);
	assign ofs      = adr.pg.ofs;

	always_comb begin
		sel = '0;
		if (page_hit) begin
			sel.joypad   = (ofs == IO_JOYP);
			sel.serial   = (ofs >= IO_SER_LO) && (ofs <= IO_SER_HI);
			sel.timer    = (ofs >= IO_TIM_LO) && (ofs <= IO_TIM_HI);
			sel.int_flag = (ofs == IO_IF);
			sel.sound    = (ofs >= IO_SND_LO) && (ofs <= IO_SND_HI);
			sel.ppu      = (ofs >= IO_PPU_LO) && (ofs <= IO_PPU_HI);
			sel.brom     = (ofs == IO_BROM);
			sel.hram     = (ofs >= IO_HRAM_LO) && (ofs <= IO_HRAM_HI);
			sel.int_ena  = (ofs == IO_IE);
		end
	end

	// register blocks never overlap inside the page.
	a_io_onehot: assert property (@(sel) $onehot0(sel))
		else $error("gb_iomap: overlapping register selects");

endmodule

//--- hdl/gb_reset_seq.sv
`timescale 1ns/100ps

module gb_reset_seq import gb_bus_pkg::*; (
	input  logic gbclk,
	input  logic n_crst_in,
	input  logic power_sw,
	input  logic cart_n_rst,
	output logic reset_gb,
	output logic reset_done,
	output logic cart_n_rst_drive
);

	logic [RST_TICK_W-1:0] init_ticks_q, init_ticks_d;
	logic                  init_done_q, init_done_d;
	logic [RST_TICK_W-1:0] ticks_q, ticks_d;
	rst_state_e            state_q, state_d;
	logic                  power_q;

	always_comb begin
		init_ticks_d = init_ticks_q;
		init_done_d  = init_done_q;
		ticks_d      = ticks_q;
		state_d      = state_q;

		if (!init_done_q)
			init_ticks_d = init_ticks_q + 1'b1;
		if (&init_ticks_q)
			init_done_d = 1'b1;

		// power toggle or cartridge pulling reset restarts the sequence.
		if (power_q != power_sw || (state_q == RST_DONE && !cart_n_rst)) begin
			state_d = RST_ASSERT;
			ticks_d = '0;
		end

		if (init_done_q) begin
			case (state_d)
			RST_ASSERT: begin
				if (power_sw) begin
					if (&ticks_d) begin
						state_d = RST_RELEASE;
						ticks_d = '0;
					end else begin
						ticks_d = ticks_d + 1'b1;
					end
				end
			end
			RST_RELEASE: begin
				// cartridge must stay out of reset for a full count.
				if (!cart_n_rst)
					ticks_d = '0;
				else if (&ticks_d)
					state_d = RST_DONE;
				else
					ticks_d = ticks_d + 1'b1;
			end
			default: ;
			endcase
		end
	end

	always_ff @(posedge gbclk) begin
		if (!n_crst_in) begin
			init_ticks_q <= '0;
			init_done_q  <= 1'b0;
			ticks_q      <= '0;
			state_q      <= RST_ASSERT;
			power_q      <= 1'b0;
		end else begin
			init_ticks_q <= init_ticks_d;
			init_done_q  <= init_done_d;
			ticks_q      <= ticks_d;
			state_q      <= state_d;
			power_q      <= power_sw;
		end
	end

	assign reset_done       = (state_d == RST_DONE);
	assign reset_gb         = !(reset_done && power_sw);
	assign cart_n_rst_drive = init_done_q && power_sw && (state_d != RST_ASSERT);

	a_no_early_done: assert property (@(posedge gbclk) disable iff (!n_crst_in)
		!init_done_q |-> !reset_done)
		else $error("gb_reset_seq: reset_done during initial count");

endmodule

//--- hdl/gb_bus_arbiter.sv
`timescale 1ns/100ps

module gb_bus_arbiter import gb_bus_pkg::*; (
	input  logic      gbclk,
	input  logic      n_crst_in,
	input  cpu_bus_t  cpu,
	input  dma_bus_t  dma,
	input  ppu_bus_t  ppu,
	input  mem_sel_t  cpu_sel,
	input  mem_sel_t  dma_sel,
	input  mem_sel_t  ppu_sel,
	output mem_port_t vram,
	output mem_port_t oam,
	output ext_port_t ext
);

	logic cpu_ext;
	logic dma_ext;
	logic ext_wr;
	logic ext_wr_q;

	function automatic logic [ADR_W-1:0] vram_ofs(input logic [ADR_W-1:0] a);
		return {{(ADR_W-VRAM_ADR_W){1'b0}}, a[VRAM_ADR_W-1:0]};
	endfunction

	function automatic logic [ADR_W-1:0] oam_ofs(input logic [OAM_ADR_W-1:0] a);
		return {{(ADR_W-OAM_ADR_W){1'b0}}, a};
	endfunction

	assign cpu_ext = cpu_sel.rom || cpu_sel.xram || cpu_sel.wram;
	assign dma_ext = dma_sel.rom || dma_sel.xram || dma_sel.wram;

	// ******************************************************************
	// vram owner is the ppu, then the dma source, then the cpu.
	// ******************************************************************
	always_comb begin
		vram       = '0;
		vram.wdata = cpu.wdata;
		if (ppu.need_vram) begin
			vram.adr = vram_ofs(ppu.adr);
			vram.rd  = ppu.rd && ppu_sel.vram;
		end else if (dma_sel.vram) begin
			vram.adr = vram_ofs(dma.adr_rd);
			vram.rd  = dma.rd;
		end else if (cpu_sel.vram) begin
			vram.adr = vram_ofs(cpu.adr);
			vram.rd  = cpu.rd;
			vram.wr  = cpu.wr;
		end
	end

	// ******************************************************************
	// oam owner is the ppu, then the dma destination, then the cpu.
	// ******************************************************************
	always_comb begin
		oam = '0;
		if (ppu.need_oam) begin
			oam.adr = oam_ofs(ppu.adr[OAM_ADR_W-1:0]);
			oam.rd  = ppu.rd && ppu_sel.oam;
		end else if (dma.active) begin
			oam.adr   = oam_ofs(dma.adr_oam);
			oam.wr    = dma.wr;
			oam.wdata = dma.wdata;
		end else if (cpu_sel.oam) begin
			oam.adr   = oam_ofs(cpu.adr[OAM_ADR_W-1:0]);
			oam.rd    = cpu.rd;
			oam.wr    = cpu.wr;
			oam.wdata = cpu.wdata;
		end
	end

	// ******************************************************************
	// external bus.
	// ******************************************************************
	assign ext_wr = !dma_ext && cpu_ext && cpu.wr;

	always_comb begin
		ext.adr     = dma_ext ? dma.adr_rd : cpu.adr;
		ext.rd      = dma_ext ? dma.rd : (cpu_ext && cpu.rd);
		ext.wr      = ext_wr;
		// data stays driven one cycle past the write.
		ext.data_oe = ext_wr || ext_wr_q;
		ext.cs_rom  = cpu_sel.rom || dma_sel.rom;
		ext.cs_xram = cpu_sel.xram || dma_sel.xram;
		ext.cs_wram = cpu_sel.wram || dma_sel.wram;
	end

	always_ff @(posedge gbclk) begin
		if (!n_crst_in)
			ext_wr_q <= 1'b0;
		else
			ext_wr_q <= ext_wr;
	end

	a_ppu_vram_ro: assert property (@(posedge gbclk) disable iff (!n_crst_in)
		ppu.need_vram |-> !vram.wr)
		else $error("gb_bus_arbiter: vram write while ppu owns vram");

endmodule

//--- hdl/gb_cpu_rdata_mux.sv
`timescale 1ns/100ps

module gb_cpu_rdata_mux import gb_bus_pkg::*; (
	input  mem_sel_t          cpu_sel,
	input  mem_sel_t          dma_sel,
	input  io_sel_t           io_sel,
	input  logic              dma_active,
	input  logic              ppu_need_vram,
	input  logic              ppu_need_oam,
	input  dev_rdata_t        dev_rdata,
	output logic [DATA_W-1:0] cpu_rdata,
	output logic [DATA_W-1:0] dma_rdata
);

	logic cpu_ext;
	logic dma_ext;
	logic dma_vram_grant;

	assign cpu_ext        = cpu_sel.rom || cpu_sel.xram || cpu_sel.wram;
	assign dma_ext        = dma_sel.rom || dma_sel.xram || dma_sel.wram;
	assign dma_vram_grant = dma_sel.vram && !ppu_need_vram;

	// first match wins.
	always_comb begin
		cpu_rdata = BUS_IDLE;
		priority case (1'b1)
		io_sel.hram:
			cpu_rdata = dev_rdata.hram;
		io_sel.joypad:
			cpu_rdata = dev_rdata.joy;
		io_sel.serial:
			cpu_rdata = dev_rdata.sio;
		io_sel.timer:
			cpu_rdata = dev_rdata.tim;
		io_sel.sound:
			cpu_rdata = dev_rdata.snd;
		io_sel.ppu:
			cpu_rdata = dev_rdata.ppu;
		io_sel.int_flag || io_sel.int_ena:
			cpu_rdata = dev_rdata.cpureg;
		cpu_sel.brom:
			cpu_rdata = dev_rdata.brom;
		cpu_sel.vram && !(dma_active && dma_sel.vram) && !ppu_need_vram:
			cpu_rdata = dev_rdata.vram;
		cpu_sel.oam && !dma_active && !ppu_need_oam:
			cpu_rdata = dev_rdata.oam;
		cpu_ext && !(dma_active && dma_ext):
			cpu_rdata = dev_rdata.ext;
		default:
			cpu_rdata = BUS_IDLE;
		endcase
	end

	always_comb begin
		if (dma_vram_grant)
			dma_rdata = dev_rdata.vram;
		else if (dma_ext)
			dma_rdata = dev_rdata.ext;
		else
			dma_rdata = BUS_IDLE;
	end

endmodule

//--- hdl/gb_bus_top.sv
`timescale 1ns/100ps

module gb_bus_top import gb_bus_pkg::*; (
	input  logic              gbclk,
	input  logic              n_crst_in,
	input  logic              power_sw,
	input  logic              cart_n_rst,
	input  logic              boot_hidden,
	input  cpu_bus_t          cpu,
	input  dma_bus_t          dma,
	input  ppu_bus_t          ppu,
	input  dev_rdata_t        dev_rdata,
	output logic [DATA_W-1:0] cpu_rdata,
	output logic [DATA_W-1:0] dma_rdata,
	output mem_port_t         vram,
	output mem_port_t         oam,
	output ext_port_t         ext,
	output io_sel_t           io_sel,
	output logic              reset_gb,
	output logic              reset_done,
	output logic              cart_n_rst_drive
);

	mem_sel_t cpu_sel;
	mem_sel_t dma_sel;
	mem_sel_t ppu_sel;

	// ******************************************************************
	// address decoders.
	// ******************************************************************
	gb_memmap cpu_map (
		.adr     (cpu.adr),
		.enable  (1'b1),
		.boot_en (!boot_hidden),
		.sel     (cpu_sel)
	);

	gb_memmap dma_map (
		.adr     (dma.adr_rd),
		.enable  (dma.active),
		.boot_en (1'b0),
		.sel     (dma_sel)
	);

	gb_memmap ppu_map (
		.adr     (ppu.adr),
		.enable  (1'b1),
		.boot_en (1'b0),
		.sel     (ppu_sel)
	);

	gb_iomap io_map (
		.adr (cpu.adr),
		.io  (cpu_sel.io),
		.sel (io_sel)
	);

	gb_reset_seq reset_seq (
		.gbclk            (gbclk),
		.n_crst_in        (n_crst_in),
		.power_sw         (power_sw),
		.cart_n_rst       (cart_n_rst),
		.reset_gb         (reset_gb),
		.reset_done       (reset_done),
		.cart_n_rst_drive (cart_n_rst_drive)
	);

	gb_bus_arbiter bus_arbiter (
		.gbclk     (gbclk),
		.n_crst_in (n_crst_in),
		.cpu       (cpu),
		.dma       (dma),
		.ppu       (ppu),
		.cpu_sel   (cpu_sel),
		.dma_sel   (dma_sel),
		.ppu_sel   (ppu_sel),
		.vram      (vram),
		.oam       (oam),
		.ext       (ext)
	);

	gb_cpu_rdata_mux rdata_mux (
		.cpu_sel       (cpu_sel),
		.dma_sel       (dma_sel),
		.io_sel        (io_sel),
		.dma_active    (dma.active),
		.ppu_need_vram (ppu.need_vram),
		.ppu_need_oam  (ppu.need_oam),
		.dev_rdata     (dev_rdata),
		.cpu_rdata     (cpu_rdata),
		.dma_rdata     (dma_rdata)
	);

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
	output logic gbclk,
	output logic n_crst_in
);

	initial begin
		gbclk = 1'b0;
		forever #2 gbclk = ~gbclk;
	end

	// reset held low for three rising edges.
	initial begin
		n_crst_in = 1'b0;
		repeat (3) @(posedge gbclk);
		#1 n_crst_in = 1'b1;
	end

endmodule

//--- tb/tb_bus_checker.sv
`timescale 1ns/100ps

module tb_bus_checker import gb_bus_pkg::*; (
	input logic              gbclk,
	input logic              n_crst_in,
	input logic              power_sw,
	input logic              boot_hidden,
	input cpu_bus_t          cpu,
	input dma_bus_t          dma,
	input logic              valid,
	input logic              predict,
	input logic [7:0]        exp_cpu,
	input logic [7:0]        exp_dma,
	input logic [2:0]        exp_cs,
	input logic [8:0]        exp_io,
	input logic [2:0]        exp_port,
	input logic [15:0]       exp_ext_adr,
	input logic [DATA_W-1:0] cpu_rdata,
	input logic [DATA_W-1:0] dma_rdata,
	input mem_port_t         vram,
	input mem_port_t         oam,
	input ext_port_t         ext,
	input io_sel_t           io_sel,
	input logic              reset_gb,
	input logic              reset_done,
	input logic              cart_n_rst_drive
);

	int value_errors = 0;
	int other_errors = 0;

	task automatic compare_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_failure(input string msg);
		other_errors++;
		$display("error: %s at %0t", msg, $time);
	endtask

	task automatic check_range(input string name, input int val, input int lo, input int hi);
		if (val < lo || val > hi)
			report_failure($sformatf("%s took %0d cycles, outside %0d..%0d", name, val, lo, hi));
	endtask

	task automatic print_summary(output int total);
		total = value_errors + other_errors;
		$display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
	endtask

	// ******************************************************************
	// memory map model giving rdata, cs and io_sel for a cpu read.
	// ******************************************************************
	function automatic logic [19:0] predict_map(input logic [15:0] a, input logic bh);
		logic [7:0] o;
		o = a[7:0];
		if (a >= 16'hff00) begin
			if (o == 8'h00) return {8'h22, 3'b000, 9'h100};
			if (o >= 8'h01 && o <= 8'h02) return {8'h33, 3'b000, 9'h080};
			if (o >= 8'h04 && o <= 8'h07) return {8'h44, 3'b000, 9'h040};
			if (o == 8'h0f) return {8'h77, 3'b000, 9'h020};
			if (o >= 8'h10 && o <= 8'h3f) return {8'h55, 3'b000, 9'h010};
			if (o >= 8'h40 && o <= 8'h4b) return {8'h66, 3'b000, 9'h008};
			// the boot rom register has a select but no read path.
			if (o == 8'h50) return {8'hff, 3'b000, 9'h004};
			if (o >= 8'h80 && o <= 8'hfe) return {8'h11, 3'b000, 9'h002};
			if (o == 8'hff) return {8'h77, 3'b000, 9'h001};
			return {8'hff, 3'b000, 9'h000};
		end
		if (a >= 16'hfe00) return {(a < 16'hfea0) ? 8'haa : 8'hff, 3'b000, 9'h000};
		if (a >= 16'hc000) return {8'hbb, 3'b001, 9'h000};
		if (a >= 16'ha000) return {8'hbb, 3'b010, 9'h000};
		if (a >= 16'h8000) return {8'h99, 3'b000, 9'h000};
		if (a < 16'h0100 && !bh) return {8'h88, 3'b000, 9'h000};
		return {8'hbb, 3'b100, 9'h000};
	endfunction

	always @(posedge gbclk) begin
		logic [19:0] p;
		#3;
		if (!n_crst_in) begin
			compare_value("reset_gb", reset_gb, 1'b1);
			compare_value("reset_done", reset_done, 1'b0);
			compare_value("cart_n_rst_drive", cart_n_rst_drive, 1'b0);
			compare_value("ext.data_oe", ext.data_oe, 1'b0);
		end else begin
			if (power_sw)
				compare_value("reset_gb", reset_gb, !reset_done);
			if (reset_done)
				compare_value("cart_n_rst_drive", cart_n_rst_drive, 1'b1);
			if (valid) begin
				compare_value("cpu_rdata", cpu_rdata, exp_cpu);
				compare_value("dma_rdata", dma_rdata, exp_dma);
				compare_value("ext.cs", {ext.cs_rom, ext.cs_xram, ext.cs_wram}, exp_cs);
				compare_value("io_sel", io_sel, exp_io);
				compare_value("oam.wr", oam.wr, exp_port[0]);
				compare_value("vram.wr", vram.wr, exp_port[1]);
				compare_value("ext.data_oe", ext.data_oe, exp_port[2]);
				compare_value("ext.adr", ext.adr, exp_ext_adr);
				// an oam write during dma carries the dma byte to the dma slot.
				if (dma.active && exp_port[0]) begin
					compare_value("oam.wdata", oam.wdata, dma.wdata);
					compare_value("oam.adr", oam.adr, {8'h00, dma.adr_oam});
				end
			end else if (predict) begin
				p = predict_map(cpu.adr, boot_hidden);
				compare_value("cpu_rdata", cpu_rdata, p[19:12]);
				compare_value("dma_rdata", dma_rdata, BUS_IDLE);
				compare_value("ext.cs", {ext.cs_rom, ext.cs_xram, ext.cs_wram}, p[11:9]);
				compare_value("io_sel", io_sel, p[8:0]);
				compare_value("ext.adr", ext.adr, cpu.adr);
			end
		end
	end

endmodule

//--- tb/tb_gb_bus_top.sv
`timescale 1ns/100ps

module tb_gb_bus_top import gb_bus_pkg::*;;

	logic              gbclk, n_crst_in;
	logic              power_sw, cart_n_rst, boot_hidden;
	cpu_bus_t          cpu;
	dma_bus_t          dma;
	ppu_bus_t          ppu;
	dev_rdata_t        dev_rdata;
	logic [DATA_W-1:0] cpu_rdata, dma_rdata;
	mem_port_t         vram, oam;
	ext_port_t         ext;
	io_sel_t           io_sel;
	logic              reset_gb, reset_done, cart_n_rst_drive;
	logic              valid, predict;
	logic [7:0]        exp_cpu, exp_dma;
	logic [2:0]        exp_cs, exp_port;
	logic [8:0]        exp_io;
	logic [15:0]       exp_ext_adr;
	logic [31:0]       seed = 32'h86f7_08a2;

	tb_clock_gen clock_gen (.gbclk(gbclk), .n_crst_in(n_crst_in));

	gb_bus_top i_gb_bus_top (.*);

	tb_bus_checker i_checker (.*);

	task automatic step();
		@(posedge gbclk);
		#1;
	endtask

	// counts cycles until reset_done is seen high late in a cycle.
	task automatic wait_done(input string what, output int cycles);
		int drive_cycles;
		cycles = 0;
		drive_cycles = 0;
		do begin
			step();
			#2;
			cycles++;
			if (cart_n_rst_drive)
				drive_cycles++;
			else if (drive_cycles != 0)
				i_checker.report_failure({what, ": cart_n_rst_drive fell before reset_done"});
		end while (!reset_done && cycles < 64);
		if (!reset_done)
			i_checker.report_failure({what, ": reset_done never rose"});
		else if (drive_cycles < 16)
			i_checker.report_failure({what, ": cart_n_rst_drive low during release"});
	endtask

	task automatic apply(input logic [7:0] f, input logic [15:0] a, input logic [15:0] d);
		cpu.rd        = f[0];
		cpu.wr        = f[1];
		dma.active    = f[2];
		dma.rd        = f[2];
		dma.wr        = f[2];
		ppu.need_vram = f[3];
		ppu.need_oam  = f[4];
		boot_hidden   = f[5];
		cpu.adr       = a;
		dma.adr_rd    = d;
	endtask

	initial begin
		int n, fd, code, total;
		string line;
		logic [7:0]  f;
		logic [15:0] a, d;
		logic [31:0] r;

		power_sw = 1'b1;
		cart_n_rst = 1'b1;
		boot_hidden = 1'b0;
		cpu = '{adr: 16'h0000, rd: 1'b0, wr: 1'b0, wdata: 8'h5a};
		dma = '{adr_rd: 16'h0000, adr_oam: 8'h10, rd: 1'b0, wr: 1'b0, active: 1'b0,
			wdata: 8'hc3};
		ppu = '{adr: 16'h8000, rd: 1'b0, need_vram: 1'b0, need_oam: 1'b0};
		// each device answers with its own byte.
		dev_rdata = {8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h66, 8'h77, 8'h88, 8'h99,
			8'haa, 8'hbb};
		valid = 1'b0;
		predict = 1'b0;
		{exp_cpu, exp_dma, exp_cs, exp_io, exp_port, exp_ext_adr} = '0;

		// ******************************************************************
		// reset sequencing.
		// ******************************************************************
		n = 0;
		while (n_crst_in !== 1'b1 && n < 20) begin
			@(posedge gbclk);
			n++;
		end
		if (n_crst_in !== 1'b1)
			i_checker.report_failure("n_crst_in was never released");
		wait_done("initial reset", n);
		i_checker.check_range("initial reset", n, 32, 56);

		step();
		cart_n_rst = 1'b0;
		#2 i_checker.compare_value("reset_done", reset_done, 1'b0);
		repeat (3) step();
		cart_n_rst = 1'b1;
		wait_done("cartridge restart", n);
		i_checker.check_range("cartridge restart", n, 16, 56);

		step();
		power_sw = 1'b0;
		#2 i_checker.compare_value("reset_done", reset_done, 1'b0);
		repeat (3) step();
		power_sw = 1'b1;
		wait_done("power restart", n);
		i_checker.check_range("power restart", n, 16, 56);

		// ******************************************************************
		// directed vectors from the stimulus file.
		// ******************************************************************
		fd = $fopen("tb/gb_bus_stimulus.txt", "r");
		if (fd == 0)
			i_checker.report_failure("cannot open tb/gb_bus_stimulus.txt");
		else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 1 && line[0] != "#") begin
					step();
					code = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f, a, d, exp_cpu,
						exp_dma, exp_cs, exp_io, exp_port, exp_ext_adr);
					apply(f, a, d);
					valid = (code == 9);
					if (code != 9)
						i_checker.report_failure("stimulus line does not hold nine fields");
				end
			end
			$fclose(fd);
		end

		// random cpu reads with dma and ppu idle.
		for (int i = 0; i < 200; i++) begin
			step();
			r = $random(seed);
			apply({2'b00, r[20], 5'b00001}, r[16] ? {8'hff, r[7:0]} : r[15:0], 16'h0000);
			valid = 1'b0;
			predict = 1'b1;
		end
		step();
		predict = 1'b0;
		apply(8'h00, 16'h0000, 16'h0000);
		step();
		#3;

		i_checker.print_summary(total);
		if (total == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- tb/gb_bus_stimulus.txt
# flags(rd=1 wr=2 dma=4 ppu_vram=8 ppu_oam=10 boot_hidden=20) cpu_adr dma_adr
# exp_cpu_rdata exp_dma_rdata exp_cs(rom,xram,wram) exp_io_sel exp_port(oe,vram_wr,oam_wr) ext_adr
01 0000 0000 88 ff 0 000 0 0000
21 0000 0000 bb ff 4 000 0 0000
01 00ff 0000 88 ff 0 000 0 00ff
01 0100 0000 bb ff 4 000 0 0100
01 8010 0000 99 ff 0 000 0 8010
01 a123 0000 bb ff 2 000 0 a123
01 c456 0000 bb ff 1 000 0 c456
01 e000 0000 bb ff 1 000 0 e000
01 fe20 0000 aa ff 0 000 0 fe20
01 fea5 0000 ff ff 0 000 0 fea5
01 ff00 0000 22 ff 0 100 0 ff00
01 ff02 0000 33 ff 0 080 0 ff02
01 ff05 0000 44 ff 0 040 0 ff05
01 ff0f 0000 77 ff 0 020 0 ff0f
01 ff20 0000 55 ff 0 010 0 ff20
01 ff45 0000 66 ff 0 008 0 ff45
01 ff50 0000 ff ff 0 004 0 ff50
01 ff90 0000 11 ff 0 002 0 ff90
01 ffff 0000 77 ff 0 001 0 ffff
01 ff60 0000 ff ff 0 000 0 ff60
09 8010 0000 ff ff 0 000 0 8010
11 fe20 0000 ff ff 0 000 0 fe20
05 fe20 c000 ff bb 1 000 1 c000
05 a100 4000 ff bb 6 000 1 4000
05 c000 8100 bb 99 1 000 1 c000
02 c010 0000 bb ff 1 000 4 c010
01 c010 0000 bb ff 1 000 4 c010
01 c010 0000 bb ff 1 000 0 c010
02 8020 0000 99 ff 0 000 2 8020
02 fe10 0000 aa ff 0 000 1 fe10
01 0200 0000 bb ff 4 000 0 0200

//--- tb.f
hdl/gb_bus_pkg.sv
hdl/gb_memmap.sv
hdl/gb_iomap.sv
hdl/gb_reset_seq.sv
hdl/gb_bus_arbiter.sv
hdl/gb_cpu_rdata_mux.sv
hdl/gb_bus_top.sv
tb/tb_clock_gen.sv
tb/tb_bus_checker.sv
tb/tb_gb_bus_top.sv
